/* Bender.yml */
package:
  name: gpsdc

sources:
  - logic/gpsdc_pkg.sv
  - logic/gps_fix_capture.sv
  - logic/serial_divider.sv
  - logic/cos_interp.sv
  - logic/haversine_unit.sv
  - logic/gpsdc_ctrl.sv
  - logic/gpsdc_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/gpsdc_tb.sv

/* logic/cos_interp.sv */
module cos_interp (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  gpsdc_pkg::deg_t      lat,
    output gpsdc_pkg::cos_addr_t cos_addr,
    input  gpsdc_pkg::deg_t      cos_x,
    input  gpsdc_pkg::cos_t      cos_y,
    output gpsdc_pkg::cos_t      cos_val,
    output logic                 done
);
    import gpsdc_pkg::*;

    typedef enum logic [1:0] {
        IP_IDLE,
        IP_WALK,
        IP_DIVIDE
    } interp_state_t;

    interp_state_t     state;
    deg_t              x0;
    cos_t              y0;
    logic [QUOT_W-1:0] prod;
    logic [DIV_W-1:0]  span;
    logic              div_start;
    logic              div_done;
    logic [QUOT_W-1:0] quotient;
    logic              above;
    deg_t              lat_off;
    cos_t              y_drop;

    // walk ends at the first entry past the latitude
    assign above = cos_x > lat;

    assign lat_off = lat - x0;

    // cosine falls over the table, so y0 - y1 is never negative
    assign y_drop = y0 - cos_y;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IP_IDLE;
            cos_addr  <= '0;
            div_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            div_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                IP_IDLE: begin
                    // entry 0 is on the bus while idle
                    if (start) begin
                        cos_addr <= cos_addr_t'(1);
                        state    <= IP_WALK;
                    end
                end
                IP_WALK: begin
                    if (above) begin
                        div_start <= 1'b1;
                        state     <= IP_DIVIDE;
                    end else begin
                        cos_addr <= cos_addr + cos_addr_t'(1);
                    end
                end
                IP_DIVIDE: begin
                    if (div_done) begin
                        done     <= 1'b1;
                        cos_addr <= '0;
                        state    <= IP_IDLE;
                    end
                end
                default: state <= IP_IDLE;
            endcase
        end
    end

    // lower bracket entry, interpolation operands and result
    always_ff @(posedge clk) begin
        if (state == IP_IDLE && start) begin
            x0 <= cos_x;
            y0 <= cos_y;
        end else if (state == IP_WALK) begin
            if (above) begin
                prod <= QUOT_W'(lat_off) * QUOT_W'(y_drop);
                span <= cos_x - x0;
            end else begin
                x0 <= cos_x;
                y0 <= cos_y;
            end
        end
        if (state == IP_DIVIDE && div_done) begin
            cos_val <= y0 - cos_t'(quotient);
        end
    end

    serial_divider div_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (div_start),
        .dividend (prod),
        .divisor  (span),
        .quotient (quotient),
        .done     (div_done)
    );

    // walk has to find its upper entry before the end of the table
    assert property (@(posedge clk) disable iff (!reset_n)
        (state == IP_WALK && !above) |-> cos_addr != cos_addr_t'(COS_DEPTH - 1));

    assert property (@(posedge clk) disable iff (!reset_n)
        div_start |-> span != '0);

endmodule

/* logic/gps_fix_capture.sv */
module gps_fix_capture (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            capture,
    input  logic            shift_cos,
    input  gpsdc_pkg::deg_t lat_in,
    input  gpsdc_pkg::deg_t lon_in,
    input  gpsdc_pkg::cos_t cos_cur,
    output gpsdc_pkg::deg_t lat_cur,
    output gpsdc_pkg::deg_t lon_cur,
    output gpsdc_pkg::deg_t lat_prev,
    output gpsdc_pkg::deg_t lon_prev,
    output gpsdc_pkg::cos_t cos_prev
);

    // fix history, current fix moves down to previous on every capture
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lat_cur  <= '0;
            lon_cur  <= '0;
            lat_prev <= '0;
            lon_prev <= '0;
        end else if (capture) begin
            lat_prev <= lat_cur;
            lon_prev <= lon_cur;
            lat_cur  <= lat_in;
            lon_cur  <= lon_in;
        end
    end

    // cosine of the previous fix
    // loaded once the current fix is fully processed
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cos_prev <= '0;
        end else if (shift_cos) begin
            cos_prev <= cos_cur;
        end
    end

endmodule

/* logic/gpsdc_ctrl.sv */
module gpsdc_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic den,
    output logic ready,
    output logic capture,
    output logic interp_start,
    input  logic interp_done,
    output logic shift_cos,
    output logic hav_start,
    input  logic hav_done
);
    import gpsdc_pkg::*;

    ctrl_state_t state;
    logic        have_prev;

    assign ready   = state == CTRL_IDLE;
    assign capture = den && ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= CTRL_IDLE;
            have_prev    <= 1'b0;
            interp_start <= 1'b0;
            hav_start    <= 1'b0;
            shift_cos    <= 1'b0;
        end else begin
            interp_start <= 1'b0;
            hav_start    <= 1'b0;
            shift_cos    <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    // new fix lands in the capture registers on this edge
                    if (capture) begin
                        interp_start <= 1'b1;
                        state        <= CTRL_INTERP;
                    end
                end
                CTRL_INTERP: begin
                    if (interp_done) begin
                        if (have_prev) begin
                            hav_start <= 1'b1;
                            state     <= CTRL_HAV;
                        end else begin
                            // first fix only seeds the history
                            have_prev <= 1'b1;
                            shift_cos <= 1'b1;
                            state     <= CTRL_IDLE;
                        end
                    end
                end
                CTRL_HAV: begin
                    if (hav_done) begin
                        shift_cos <= 1'b1;
                        state     <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        !(interp_start && hav_start));

endmodule

/* logic/gpsdc_pkg.sv */
package gpsdc_pkg;

    // fraction bits of the cosine, radian and square formats
    localparam int FRAC_BITS = 32;

    // cosine table depth, one entry per whole degree
    localparam int COS_DEPTH = 128;

    // pi / 180 with 16 fraction bits
    localparam logic [15:0] RAD_PER_DEG = 16'h0477;

    // divider widths
    localparam int QUOT_W = 64;
    localparam int DIV_W = 24;
    localparam int DIV_CNT_W = $clog2(QUOT_W + 1);

    // 8.16 degrees
    typedef logic [23:0] deg_t;

    // 8.32 cosine
    typedef logic [39:0] cos_t;

    // 8.32 radians
    typedef logic [39:0] rad_t;

    // 32.32 squares and haversine term
    typedef logic [63:0] frac_t;

    typedef logic [$clog2(COS_DEPTH)-1:0] cos_addr_t;

    // top level sequencing
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_INTERP,
        CTRL_HAV
    } ctrl_state_t;

endpackage

/* logic/gpsdc_top.sv */
module gpsdc_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 den,
    input  gpsdc_pkg::deg_t      lat_in,
    input  gpsdc_pkg::deg_t      lon_in,
    output logic                 ready,
    output gpsdc_pkg::cos_addr_t cos_addr,
    input  gpsdc_pkg::deg_t      cos_x,
    input  gpsdc_pkg::cos_t      cos_y,
    output logic                 valid,
    output gpsdc_pkg::frac_t     a
);
    import gpsdc_pkg::*;

    logic capture;
    logic interp_start;
    logic interp_done;
    logic shift_cos;
    logic hav_start;
    deg_t lat_cur;
    deg_t lon_cur;
    deg_t lat_prev;
    deg_t lon_prev;
    cos_t cos_cur;
    cos_t cos_prev;

    gpsdc_ctrl ctrl_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .den          (den),
        .ready        (ready),
        .capture      (capture),
        .interp_start (interp_start),
        .interp_done  (interp_done),
        .shift_cos    (shift_cos),
        .hav_start    (hav_start),
        .hav_done     (valid)
    );

    gps_fix_capture capture_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .capture   (capture),
        .shift_cos (shift_cos),
        .lat_in    (lat_in),
        .lon_in    (lon_in),
        .cos_cur   (cos_cur),
        .lat_cur   (lat_cur),
        .lon_cur   (lon_cur),
        .lat_prev  (lat_prev),
        .lon_prev  (lon_prev),
        .cos_prev  (cos_prev)
    );

    cos_interp interp_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (interp_start),
        .lat      (lat_cur),
        .cos_addr (cos_addr),
        .cos_x    (cos_x),
        .cos_y    (cos_y),
        .cos_val  (cos_cur),
        .done     (interp_done)
    );

    haversine_unit hav_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (hav_start),
        .lat_cur  (lat_cur),
        .lon_cur  (lon_cur),
        .lat_prev (lat_prev),
        .lon_prev (lon_prev),
        .cos_cur  (cos_cur),
        .cos_prev (cos_prev),
        .a        (a),
        .valid    (valid)
    );

endmodule

/* logic/haversine_unit.sv */
module haversine_unit (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start,
    input  gpsdc_pkg::deg_t  lat_cur,
    input  gpsdc_pkg::deg_t  lon_cur,
    input  gpsdc_pkg::deg_t  lat_prev,
    input  gpsdc_pkg::deg_t  lon_prev,
    input  gpsdc_pkg::cos_t  cos_cur,
    input  gpsdc_pkg::cos_t  cos_prev,
    output gpsdc_pkg::frac_t a,
    output logic             valid
);
    import gpsdc_pkg::*;

    deg_t  dlat;
    deg_t  dlon;
    rad_t  rlat;
    rad_t  rlon;
    frac_t cprod;
    frac_t sq_lat;
    frac_t sq_lon;
    frac_t term;
    logic [3:0] stage;
    logic [2*$bits(rad_t)-1:0]  rlat_sq;
    logic [2*$bits(rad_t)-1:0]  rlon_sq;
    logic [2*$bits(cos_t)-1:0]  cos_sq;
    logic [2*$bits(frac_t)-1:0] lon_wt;

    function automatic deg_t abs_diff(deg_t p, deg_t q);
        return (p >= q) ? p - q : q - p;
    endfunction

    // full-width products, truncated when registered
    assign rlat_sq = rlat * rlat;
    assign rlon_sq = rlon * rlon;
    assign cos_sq  = cos_cur * cos_prev;
    assign lon_wt  = cprod * sq_lon;

    // one-hot step tracker
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage <= '0;
            valid <= 1'b0;
        end else begin
            stage <= {stage[2:0], start};
            valid <= stage[3];
        end
    end

    always_ff @(posedge clk) begin
        // step 0, absolute differences
        if (start) begin
            dlat <= abs_diff(lat_cur, lat_prev);
            dlon <= abs_diff(lon_cur, lon_prev);
        end
        // step 1, degrees to radians and the cosine product
        if (stage[0]) begin
            rlat  <= dlat * RAD_PER_DEG;
            rlon  <= dlon * RAD_PER_DEG;
            cprod <= frac_t'(cos_sq >> FRAC_BITS);
        end
        // step 2, squares
        if (stage[1]) begin
            sq_lat <= frac_t'(rlat_sq >> FRAC_BITS);
            sq_lon <= frac_t'(rlon_sq >> FRAC_BITS);
        end
        // step 3, longitude term scaled by both cosines
        if (stage[2]) begin
            term <= frac_t'(lon_wt >> FRAC_BITS);
        end
        if (stage[3]) begin
            a <= sq_lat + term;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        valid |=> !valid);

endmodule

/* logic/serial_divider.sv */
module serial_divider (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start,
    input  logic [gpsdc_pkg::QUOT_W-1:0] dividend,
    input  logic [gpsdc_pkg::DIV_W-1:0]  divisor,
    output logic [gpsdc_pkg::QUOT_W-1:0] quotient,
    output logic                         done
);
    import gpsdc_pkg::*;

    logic [DIV_W-1:0]     rem;
    logic [DIV_W-1:0]     dvsr;
    logic [DIV_CNT_W-1:0] steps_left;
    logic [DIV_W:0]       trial;
    logic [DIV_W:0]       diff;
    logic                 fits;

    // next dividend bit comes from the top of the shifting quotient register
    assign trial = {rem, quotient[QUOT_W-1]};
    assign diff  = trial - {1'b0, dvsr};
    assign fits  = trial >= {1'b0, dvsr};

    // step counter, done on the last step
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            steps_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                steps_left <= DIV_CNT_W'(QUOT_W);
            end else if (steps_left != '0) begin
                steps_left <= steps_left - DIV_CNT_W'(1);
                if (steps_left == DIV_CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // restoring step, one quotient bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            rem      <= '0;
            dvsr     <= divisor;
            quotient <= dividend;
        end else if (steps_left != '0) begin
            if (fits) begin
                rem <= diff[DIV_W-1:0];
            end else begin
                rem <= trial[DIV_W-1:0];
            end
            quotient <= {quotient[QUOT_W-2:0], fits};
        end
    end

endmodule

/* sim.f */
logic/gpsdc_pkg.sv
logic/gps_fix_capture.sv
logic/serial_divider.sv
logic/cos_interp.sv
logic/haversine_unit.sv
logic/gpsdc_ctrl.sv
logic/gpsdc_top.sv
test/tb_clock_gen.sv
test/gpsdc_tb.sv

/* test/gpsdc_tb.sv */
module gpsdc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import gpsdc_pkg::*;

    localparam int TIMEOUT  = 1000;
    localparam int N_RANDOM = 40;
    localparam int LAT_MAX  = 120 * 65536 - 1;

    logic      clk;
    logic      reset_n;
    logic      den;
    deg_t      lat_in;
    deg_t      lon_in;
    logic      ready;
    cos_addr_t cos_addr;
    deg_t      cos_x;
    cos_t      cos_y;
    logic      valid;
    frac_t     a;

    // cosine table model, one entry per whole degree
    deg_t tab_x [COS_DEPTH];
    cos_t tab_y [COS_DEPTH];

    frac_t exp_q [$];
    int    value_errors;
    int    other_errors;
    int    valid_count;
    frac_t last_a;

    // last accepted fix
    logic have_prev;
    deg_t prev_lat;
    deg_t prev_lon;
    cos_t prev_cos;

    tb_clock_gen clk_gen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    gpsdc_top dut_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .den      (den),
        .lat_in   (lat_in),
        .lon_in   (lon_in),
        .ready    (ready),
        .cos_addr (cos_addr),
        .cos_x    (cos_x),
        .cos_y    (cos_y),
        .valid    (valid),
        .a        (a)
    );

    // combinational table read
    assign cos_x = tab_x[cos_addr];
    assign cos_y = tab_y[cos_addr];

    function automatic void build_table();
        real c;
        for (int k = 0; k < COS_DEPTH; k++) begin
            c = $cos(k * 3.14159265358979 / 180.0);
            tab_x[k] = deg_t'(k << 16);
            // negative cosines wrap to two's complement in 40 bits
            tab_y[k] = cos_t'(longint'(c * 4294967296.0));
        end
    endfunction

    // bracket the latitude in the table, then interpolate
    function automatic cos_t ref_cos(deg_t lat);
        int          addr;
        deg_t        off;
        deg_t        span;
        cos_t        drop;
        logic [63:0] prod;
        logic [63:0] quot;
        addr = 1;
        while (addr < COS_DEPTH - 1 && tab_x[addr] <= lat) begin
            addr++;
        end
        off  = lat - tab_x[addr-1];
        span = tab_x[addr] - tab_x[addr-1];
        drop = tab_y[addr-1] - tab_y[addr];
        prod = 64'(off) * 64'(drop);
        quot = prod / 64'(span);
        return tab_y[addr-1] - cos_t'(quot);
    endfunction

    // small-angle haversine term, all truncation toward zero
    function automatic frac_t ref_hav(deg_t lat_c, deg_t lon_c, deg_t lat_p, deg_t lon_p,
                                      cos_t cos_c, cos_t cos_p);
        deg_t         dlat;
        deg_t         dlon;
        rad_t         rlat;
        rad_t         rlon;
        logic [79:0]  wide;
        logic [127:0] wider;
        frac_t        sq_lat;
        frac_t        sq_lon;
        frac_t        cprod;
        dlat = (lat_c >= lat_p) ? lat_c - lat_p : lat_p - lat_c;
        dlon = (lon_c >= lon_p) ? lon_c - lon_p : lon_p - lon_c;
        rlat = 40'(dlat) * 40'(RAD_PER_DEG);
        rlon = 40'(dlon) * 40'(RAD_PER_DEG);
        wide   = 80'(rlat) * 80'(rlat);
        sq_lat = frac_t'(wide >> 32);
        wide   = 80'(rlon) * 80'(rlon);
        sq_lon = frac_t'(wide >> 32);
        wide   = 80'(cos_c) * 80'(cos_p);
        cprod  = frac_t'(wide >> 32);
        wider  = 128'(cprod) * 128'(sq_lon);
        return sq_lat + frac_t'(wider >> 32);
    endfunction

    // result checker, one compare per valid pulse
    always @(negedge clk) begin
        frac_t expected;
        if (reset_n === 1'b1 && valid === 1'b1) begin
            valid_count++;
            last_a = a;
            assert (exp_q.size() > 0)
            else begin
                other_errors++;
                $display("valid pulsed while no result was expected");
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (a === expected)
                else begin
                    value_errors++;
                    $display("FAILED a: got %h, expected %h", a, expected);
                end
            end
        end
    end

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (reset_n === 1'b1)
        else begin
            other_errors++;
            $display("reset was never released");
            finish_run();
        end
        @(negedge clk);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (ready !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (ready === 1'b1)
        else begin
            other_errors++;
            $display("ready did not come back within %0d cycles", TIMEOUT);
            finish_run();
        end
    endtask

    // one fix through the DUT, optionally with den pulses while busy
    task automatic send_fix(deg_t lat, deg_t lon, cos_t cos_ref, bit poke_busy);
        int count_before;
        wait_ready();
        count_before = valid_count;
        if (have_prev) begin
            exp_q.push_back(ref_hav(lat, lon, prev_lat, prev_lon, cos_ref, prev_cos));
        end
        den    = 1'b1;
        lat_in = lat;
        lon_in = lon;
        @(negedge clk);
        den = 1'b0;
        assert (ready === 1'b0)
        else begin
            other_errors++;
            $display("fix was not taken although ready was high");
        end
        if (poke_busy) begin
            repeat (3) begin
                assert (ready === 1'b0)
                else begin
                    other_errors++;
                    $display("DUT was not busy during the ignored den pulses");
                end
                den    = 1'b1;
                lat_in = deg_t'($urandom_range(LAT_MAX, 0));
                lon_in = deg_t'($urandom);
                @(negedge clk);
            end
            den = 1'b0;
        end
        wait_ready();
        if (have_prev) begin
            assert (valid_count == count_before + 1)
            else begin
                other_errors++;
                $display("expected exactly one valid pulse for this fix");
            end
        end else begin
            assert (valid_count == count_before)
            else begin
                other_errors++;
                $display("first fix after reset produced a valid pulse");
            end
        end
        have_prev = 1'b1;
        prev_lat  = lat;
        prev_lon  = lon;
        prev_cos  = cos_ref;
    endtask

    initial begin
        deg_t lat;
        deg_t lon;
        build_table();
        den          = 1'b0;
        lat_in       = '0;
        lon_in       = '0;
        value_errors = 0;
        other_errors = 0;
        valid_count  = 0;
        last_a       = '0;
        have_prev    = 1'b0;
        prev_lat     = '0;
        prev_lon     = '0;
        prev_cos     = '0;
        void'($urandom(32'h63134bba));

        wait_reset_release();
        assert (ready === 1'b1)
        else begin
            value_errors++;
            $display("FAILED ready after reset: got %h, expected 1", ready);
        end
        assert (valid === 1'b0)
        else begin
            value_errors++;
            $display("FAILED valid after reset: got %h, expected 0", valid);
        end
        assert (cos_addr === '0)
        else begin
            value_errors++;
            $display("FAILED cos_addr after reset: got %h, expected 00", cos_addr);
        end

        // first fix only seeds the history
        lat = deg_t'($urandom_range(LAT_MAX, 0));
        lon = deg_t'($urandom);
        send_fix(lat, lon, ref_cos(lat), 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            lat = deg_t'($urandom_range(LAT_MAX, 0));
            lon = deg_t'($urandom);
            send_fix(lat, lon, ref_cos(lat), 1'b0);
        end

        // same fix twice
        lat = deg_t'($urandom_range(LAT_MAX, 0));
        lon = deg_t'($urandom);
        send_fix(lat, lon, ref_cos(lat), 1'b0);
        send_fix(lat, lon, ref_cos(lat), 1'b0);
        assert (last_a === '0)
        else begin
            value_errors++;
            $display("FAILED a for a repeated fix: got %h, expected 0", last_a);
        end

        // whole degrees hit table entries exactly
        for (int k = 0; k < 120; k += 13) begin
            lat = deg_t'(k << 16);
            lon = deg_t'($urandom);
            send_fix(lat, lon, tab_y[k], 1'b0);
        end

        // den while busy must not disturb the pairing
        lat = deg_t'($urandom_range(LAT_MAX, 0));
        lon = deg_t'($urandom);
        send_fix(lat, lon, ref_cos(lat), 1'b1);
        lat = deg_t'($urandom_range(LAT_MAX, 0));
        lon = deg_t'($urandom);
        send_fix(lat, lon, ref_cos(lat), 1'b0);

        assert (exp_q.size() == 0)
        else begin
            other_errors++;
            $display("%0d expected results never appeared", exp_q.size());
        end
        finish_run();
    end

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release lands on a falling edge, away from the flops
    initial begin
        reset_n = 1'b0;
        #(PERIOD_NS * RESET_CYCLES) reset_n = 1'b1;
    end

endmodule
